//--- genesis_macros.svh
// Address map and sizing constants for the 68000 main-bus arbiter.
// Include in any file that needs fixed addresses or the reset open-bus word.
// Addresses are byte addresses; compare them against {addr, 1'b0}.

`ifndef GENESIS_MACROS_SVH
`define GENESIS_MACROS_SVH

// Open-bus word after reset (68000 NOP opcode)
`define GEN_NO_DATA_RESET 16'h4E71

// ROM bank mapper
`define GEN_BANK_COUNT 8
`define GEN_BANK_BASE 24'hA13000
`define GEN_BANK_ROM_MIN 24'h200000

// Z80 control registers
`define GEN_CTRL_BUSREQ 24'hA11100
`define GEN_CTRL_RESET 24'hA11200

// End of cartridge ROM space
`define GEN_ROM_AREA_END 24'hA00000

// Work RAM depth in 16-bit words
`define GEN_RAM_WORDS 32768

`endif

//--- mbus_pkg.sv
// Bus transaction types shared by the main-bus controller and its devices.
// Import with a wildcard in the module header.

`default_nettype none

package mbus_pkg;

	// Word address, bits 23 to 1 of the 68000 address
	typedef logic [23:1] mbus_addr_t;

	typedef logic [15:0] mbus_data_t;

	// Controller FSM states
	typedef enum logic [2:0] {
		IDLE,
		SELECT,
		RAM_READ,
		ROM_READ,
		FINISH
	} mbus_state_e;

endpackage

`default_nettype wire

//--- memmap_pkg.sv
// Memory map types for the decoder and the ROM bank mapper.
// Import with a wildcard in the module header.

`default_nettype none

package memmap_pkg;

	// Decoded target of a main-bus transaction
	typedef enum logic [2:0] {
		ROM,
		ROM_EMPTY,
		RAM,
		BANK_REG,
		Z80_CTRL,
		NONE
	} mbus_region_e;

	typedef logic [4:0] bank_t;
	typedef logic [2:0] bank_idx_t;

endpackage

`default_nettype wire

//--- mbus_if.sv
// Latched main-bus transaction, driven by the controller and read by
// the decoder, the bank mapper, the work RAM and the Z80 control block.

`timescale 1ns/100ps
`default_nettype none

interface mbus_if import mbus_pkg::*; ();

	mbus_addr_t addr;
	mbus_data_t wdata;
	// Strobes are active high inside the design
	logic rnw;
	logic uds;
	logic lds;

	modport ctrl (output addr, wdata, rnw, uds, lds);
	modport dev (input addr, wdata, rnw, uds, lds);

endinterface

`default_nettype wire

//--- mbus_decode.sv
// Address decoder for the latched main-bus transaction.
// Purely combinational; the controller samples region in SELECT.

`timescale 1ns/100ps
`default_nettype none

`include "genesis_macros.svh"

module mbus_decode import mbus_pkg::*, memmap_pkg::*; (
	mbus_if.dev bus,
	input mbus_addr_t romsz,
	output mbus_region_e region
);

	localparam logic [23:0] ROM_AREA_END = `GEN_ROM_AREA_END;
	localparam logic [23:0] BANK_BASE = `GEN_BANK_BASE;
	localparam logic [23:0] CTRL_BASE = `GEN_CTRL_BUSREQ;

	logic [23:0] byte_addr;

	assign byte_addr = {bus.addr, 1'b0};

	always_comb begin
		region = NONE;
		if (byte_addr < ROM_AREA_END) begin
			// Past the end of the cartridge reads back zero
			region = (bus.addr < romsz) ? ROM : ROM_EMPTY;
		end else if (byte_addr[23:8] == BANK_BASE[23:8]) begin
			region = BANK_REG;
		end else if (byte_addr[23:12] == CTRL_BASE[23:12] && byte_addr[7:1] == '0) begin
			// A11000 page, only the word at offset 0 of each 256-byte block
			region = Z80_CTRL;
		end else if (&byte_addr[23:21]) begin
			region = RAM;
		end
	end

endmodule

`default_nettype wire

//--- rom_mapper.sv
// Eight-entry ROM bank mapper for cartridges larger than 2 MB.
// Banking is off until the first write to a nonzero register; after that
// the upper address bits select a 512 KB bank through the register file.

`timescale 1ns/100ps
`default_nettype none

`include "genesis_macros.svh"

module rom_mapper import mbus_pkg::*, memmap_pkg::*; (
	input logic MCLK,
	input logic reset,
	mbus_if.dev bus,
	input mbus_addr_t romsz,
	input logic bank_we,
	output mbus_addr_t rom_addr
);

	localparam logic [23:0] BANK_ROM_MIN = `GEN_BANK_ROM_MIN;

	bank_t bank_regs [`GEN_BANK_COUNT];
	logic bank_rom;
	bank_idx_t wr_idx;
	bank_idx_t rd_idx;

	assign wr_idx = bus.addr[3:1];
	assign rd_idx = bus.addr[21:19];

	always_ff @(posedge MCLK) begin
		if (reset) begin
			bank_rom <= 1'b0;
			for (int i = 0; i < `GEN_BANK_COUNT; i++) begin
				bank_regs[i] <= bank_t'(i);
			end
		end else if (bank_we && wr_idx != '0 && {romsz, 1'b0} > BANK_ROM_MIN) begin
			// Register 0 stays fixed so the vector table is always visible
			bank_regs[wr_idx] <= bus.wdata[4:0];
			bank_rom <= 1'b1;
		end
	end

	assign rom_addr = bank_rom ? {bank_regs[rd_idx], bus.addr[18:1]} : bus.addr;

	a_bank_we_write: assert property (@(posedge MCLK) disable iff (reset)
		bank_we |-> !bus.rnw);

endmodule

`default_nettype wire

//--- work_ram.sv
// 64 KB 68000 work RAM as two byte-wide arrays.
// Writes land on the strobe edge, read data follows one cycle after the address.

`timescale 1ns/100ps
`default_nettype none

`include "genesis_macros.svh"

module work_ram import mbus_pkg::*; (
	input logic MCLK,
	mbus_if.dev bus,
	input logic ram_we,
	output mbus_data_t ram_q
);

	logic [7:0] ram_hi [`GEN_RAM_WORDS];
	logic [7:0] ram_lo [`GEN_RAM_WORDS];

	always_ff @(posedge MCLK) begin
		if (ram_we && bus.uds) begin
			ram_hi[bus.addr[15:1]] <= bus.wdata[15:8];
		end
		if (ram_we && bus.lds) begin
			ram_lo[bus.addr[15:1]] <= bus.wdata[7:0];
		end
		ram_q <= {ram_hi[bus.addr[15:1]], ram_lo[bus.addr[15:1]]};
	end

endmodule

`default_nettype wire

//--- z80_ctrl_regs.sv
// Z80 bus-request and reset registers as seen from the 68000.
// Only the upper byte lane is decoded; bit 8 carries the flag and the
// rest of a read returns the open-bus word.

`timescale 1ns/100ps
`default_nettype none

`include "genesis_macros.svh"

module z80_ctrl_regs import mbus_pkg::*; (
	input logic MCLK,
	input logic reset,
	mbus_if.dev bus,
	input logic ctrl_we,
	input mbus_data_t open_bus,
	input logic z80_busack,
	output mbus_data_t ctrl_q,
	output logic z80_busreq,
	output logic z80_reset_n
);

	localparam logic [23:0] BUSREQ_ADDR = `GEN_CTRL_BUSREQ;
	localparam logic [23:0] RESET_ADDR = `GEN_CTRL_RESET;

	logic sel_busreq;
	logic sel_reset;
	logic flag;

	// Register select on address bits 11 to 8
	assign sel_busreq = (bus.addr[11:8] == BUSREQ_ADDR[11:8]);
	assign sel_reset = (bus.addr[11:8] == RESET_ADDR[11:8]);

	always_ff @(posedge MCLK) begin
		if (reset) begin
			z80_busreq <= 1'b0;
			z80_reset_n <= 1'b0;
		end else if (ctrl_we && bus.uds) begin
			if (sel_busreq) z80_busreq <= bus.wdata[8];
			if (sel_reset) z80_reset_n <= bus.wdata[8];
		end
	end

	// Bus granted reads back as 0
	assign flag = sel_busreq ? ~z80_busack : (sel_reset ? z80_reset_n : open_bus[8]);
	assign ctrl_q = {open_bus[15:9], flag, open_bus[7:0]};

endmodule

`default_nettype wire

//--- mbus_ctrl.sv
// Main-bus controller for 68000 transactions.
// Latches a cycle from the CPU strobes, dispatches it on the decoded region,
// runs the toggle handshake for ROM reads and answers with dtack.
// Also keeps the open-bus word returned for unmapped reads.

`timescale 1ns/100ps
`default_nettype none

`include "genesis_macros.svh"

module mbus_ctrl import mbus_pkg::*, memmap_pkg::*; (
	input logic MCLK,
	input logic reset,
	input logic cpu_as,
	input logic cpu_rnw,
	input logic cpu_uds,
	input logic cpu_lds,
	input mbus_addr_t cpu_addr,
	input mbus_data_t cpu_wdata,
	output mbus_data_t cpu_rdata,
	output logic cpu_dtack,
	mbus_if.ctrl bus,
	input mbus_region_e region,
	input mbus_data_t ram_q,
	input mbus_data_t ctrl_q,
	output logic ram_we,
	output logic bank_we,
	output logic ctrl_we,
	output mbus_data_t open_bus,
	output logic rom_req,
	input logic rom_ack,
	input mbus_data_t rom_data
);

	mbus_state_e state;
	mbus_data_t read_data;
	logic wr_select;

	// ------------------------------
	// Device write strobes
	// ------------------------------
	assign wr_select = (state == SELECT) && !bus.rnw;
	assign ram_we = wr_select && (region == RAM);
	assign bank_we = wr_select && (region == BANK_REG);
	assign ctrl_we = wr_select && (region == Z80_CTRL);

	// ------------------------------
	// Transaction FSM
	// ------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			state <= IDLE;
			cpu_dtack <= 1'b0;
			rom_req <= 1'b0;
			open_bus <= `GEN_NO_DATA_RESET;
			bus.rnw <= 1'b1;
			bus.uds <= 1'b0;
			bus.lds <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (cpu_as && !cpu_dtack) begin
						bus.rnw <= cpu_rnw;
						bus.uds <= cpu_uds;
						bus.lds <= cpu_lds;
						state <= SELECT;
					end
				end
				SELECT: begin
					// Everything but a ROM read spends one settle cycle in RAM_READ
					state <= RAM_READ;
					if (region == ROM && bus.rnw) begin
						rom_req <= ~rom_ack;
						state <= ROM_READ;
					end
				end
				RAM_READ: begin
					if (region == RAM && bus.rnw) begin
						open_bus <= ram_q;
					end
					state <= FINISH;
				end
				ROM_READ: begin
					if (rom_req == rom_ack) begin
						open_bus <= rom_data;
						state <= FINISH;
					end
				end
				FINISH: begin
					// Hold dtack until the CPU releases the strobe
					if (cpu_as) begin
						cpu_dtack <= 1'b1;
					end else begin
						cpu_dtack <= 1'b0;
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// ------------------------------
	// Transaction payload and read data
	// ------------------------------
	always_ff @(posedge MCLK) begin
		if (state == IDLE && cpu_as && !cpu_dtack) begin
			bus.addr <= cpu_addr;
			bus.wdata <= cpu_wdata;
		end
		if (state == SELECT) begin
			case (region)
				ROM_EMPTY: read_data <= '0;
				Z80_CTRL: read_data <= ctrl_q;
				default: read_data <= open_bus;
			endcase
		end
		if (state == RAM_READ && region == RAM) read_data <= ram_q;
		if (state == ROM_READ && rom_req == rom_ack) read_data <= rom_data;
		if (state == FINISH) cpu_rdata <= read_data;
	end

	a_rom_req_entry: assert property (@(posedge MCLK) disable iff (reset)
		$changed(rom_req) |-> state == ROM_READ && $past(state) == SELECT);

	a_no_dtack_idle: assert property (@(posedge MCLK) disable iff (reset)
		state == IDLE |-> !cpu_dtack);

endmodule

`default_nettype wire

//--- genesis_mbus_top.sv
// Top level of the 68000 main-bus arbiter.
// The CPU drives plain active-high strobes; the cartridge ROM sits behind
// a toggle request/acknowledge port.

`timescale 1ns/100ps
`default_nettype none

module genesis_mbus_top import mbus_pkg::*, memmap_pkg::*; (
	input logic MCLK,
	input logic reset,
	input logic cpu_as,
	input logic cpu_rnw,
	input logic cpu_uds,
	input logic cpu_lds,
	input mbus_addr_t cpu_addr,
	input mbus_data_t cpu_wdata,
	output mbus_data_t cpu_rdata,
	output logic cpu_dtack,
	input mbus_addr_t romsz,
	output mbus_addr_t rom_addr,
	output logic rom_req,
	input logic rom_ack,
	input mbus_data_t rom_data,
	input logic z80_busack,
	output logic z80_busreq,
	output logic z80_reset_n
);

	mbus_region_e region;
	mbus_data_t ram_q;
	mbus_data_t ctrl_q;
	mbus_data_t open_bus;
	logic ram_we;
	logic bank_we;
	logic ctrl_we;

	mbus_if u_bus ();

	// ------------------------------
	// Controller
	// ------------------------------
	mbus_ctrl u_mbus_ctrl (
		.MCLK(MCLK),
		.reset(reset),
		.cpu_as(cpu_as),
		.cpu_rnw(cpu_rnw),
		.cpu_uds(cpu_uds),
		.cpu_lds(cpu_lds),
		.cpu_addr(cpu_addr),
		.cpu_wdata(cpu_wdata),
		.cpu_rdata(cpu_rdata),
		.cpu_dtack(cpu_dtack),
		.bus(u_bus.ctrl),
		.region(region),
		.ram_q(ram_q),
		.ctrl_q(ctrl_q),
		.ram_we(ram_we),
		.bank_we(bank_we),
		.ctrl_we(ctrl_we),
		.open_bus(open_bus),
		.rom_req(rom_req),
		.rom_ack(rom_ack),
		.rom_data(rom_data)
	);

	// ------------------------------
	// Datapath devices
	// ------------------------------
	mbus_decode u_mbus_decode (
		.bus(u_bus.dev),
		.romsz(romsz),
		.region(region)
	);

	rom_mapper u_rom_mapper (
		.MCLK(MCLK),
		.reset(reset),
		.bus(u_bus.dev),
		.romsz(romsz),
		.bank_we(bank_we),
		.rom_addr(rom_addr)
	);

	work_ram u_work_ram (
		.MCLK(MCLK),
		.bus(u_bus.dev),
		.ram_we(ram_we),
		.ram_q(ram_q)
	);

	z80_ctrl_regs u_z80_ctrl_regs (
		.MCLK(MCLK),
		.reset(reset),
		.bus(u_bus.dev),
		.ctrl_we(ctrl_we),
		.open_bus(open_bus),
		.z80_busack(z80_busack),
		.ctrl_q(ctrl_q),
		.z80_busreq(z80_busreq),
		.z80_reset_n(z80_reset_n)
	);

endmodule

`default_nettype wire

//--- tb_genesis_mbus.sv
// Self-checking testbench for the 68000 main-bus arbiter.
// Replays mbus_golden.txt one bus transaction per line, models the cartridge
// ROM behind the toggle handshake and checks read data, ROM addresses,
// Z80 control pins and dtack latency.

`timescale 1ns/100ps
`default_nettype none

module tb_genesis_mbus import mbus_pkg::*; ();

	localparam int WAIT_LIMIT = 100;
	localparam logic [23:0] ROM_BYTES = 24'h400000;

	logic MCLK;
	logic reset;
	logic cpu_as;
	logic cpu_rnw;
	logic cpu_uds;
	logic cpu_lds;
	mbus_addr_t cpu_addr;
	mbus_data_t cpu_wdata;
	mbus_data_t cpu_rdata;
	logic cpu_dtack;
	mbus_addr_t romsz;
	mbus_addr_t rom_addr;
	logic rom_req;
	logic rom_ack = 1'b0;
	mbus_data_t rom_data = '0;
	logic z80_busack;
	logic z80_busreq;
	logic z80_reset_n;

	// ROM model state
	logic [31:0] rng_state = 32'd83;
	int rom_delay;
	mbus_addr_t rom_seen_addr;

	// Golden file fields
	int fd;
	int code;
	int ch;
	int lines_run;
	int latency;
	logic done;
	logic [7:0] op;
	logic [23:0] f_addr;
	logic [15:0] f_wdata;
	logic [1:0] f_strb;
	logic [23:0] f_exp;
	mbus_data_t rdata;

	genesis_mbus_top u_genesis_mbus_top (
		.MCLK(MCLK),
		.reset(reset),
		.cpu_as(cpu_as),
		.cpu_rnw(cpu_rnw),
		.cpu_uds(cpu_uds),
		.cpu_lds(cpu_lds),
		.cpu_addr(cpu_addr),
		.cpu_wdata(cpu_wdata),
		.cpu_rdata(cpu_rdata),
		.cpu_dtack(cpu_dtack),
		.romsz(romsz),
		.rom_addr(rom_addr),
		.rom_req(rom_req),
		.rom_ack(rom_ack),
		.rom_data(rom_data),
		.z80_busack(z80_busack),
		.z80_busreq(z80_busreq),
		.z80_reset_n(z80_reset_n)
	);

	initial begin
		MCLK = 1'b0;
		forever #2 MCLK = ~MCLK;
	end

	// ------------------------------
	// Helpers
	// ------------------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Cartridge contents are the low 16 bits of the word address XOR A5A5
	function automatic mbus_data_t rom_word(input mbus_addr_t addr);
		return addr[16:1] ^ 16'hA5A5;
	endfunction

	task automatic stop_run();
		$display("TEST FAILED");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic fail_run(input string reason);
		$display("%s", reason);
		stop_run();
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("[FAIL] %s: got %0h, expected %0h", name, actual, expected);
			stop_run();
		end
	endtask

	// One 68000 cycle from the address strobe to the fall of dtack
	task automatic bus_cycle(input logic rnw, input logic [23:0] byte_addr,
		input mbus_data_t wdata, input logic [1:0] strb,
		output mbus_data_t rd, output int cycles);
		int waited;
		@(posedge MCLK);
		cpu_addr <= byte_addr[23:1];
		cpu_wdata <= wdata;
		cpu_rnw <= rnw;
		cpu_uds <= strb[1];
		cpu_lds <= strb[0];
		cpu_as <= 1'b1;
		@(negedge MCLK);
		waited = 1;
		while (!cpu_dtack) begin
			if (waited >= WAIT_LIMIT) fail_run("Timed out waiting for cpu_dtack to rise");
			@(negedge MCLK);
			waited++;
		end
		rd = cpu_rdata;
		// cpu_as is sampled one edge after the drive
		cycles = waited - 2;
		@(posedge MCLK);
		cpu_as <= 1'b0;
		@(negedge MCLK);
		waited = 1;
		while (cpu_dtack) begin
			if (waited >= WAIT_LIMIT) fail_run("Timed out waiting for cpu_dtack to fall");
			@(negedge MCLK);
			waited++;
		end
	endtask

	// ------------------------------
	// ROM model answering each toggle after 0 to 3 cycles
	// ------------------------------
	always begin
		@(posedge MCLK);
		if (!reset && rom_req != rom_ack) begin
			rng_state = xorshift32(rng_state);
			rom_delay = rng_state[1:0];
			rom_seen_addr = rom_addr;
			repeat (rom_delay) @(posedge MCLK);
			rom_data <= rom_word(rom_addr);
			rom_ack <= rom_req;
		end
	end

	// ------------------------------
	// Golden file replay
	// ------------------------------
	initial begin
		reset = 1'b1;
		cpu_as = 1'b0;
		cpu_rnw = 1'b1;
		cpu_uds = 1'b0;
		cpu_lds = 1'b0;
		cpu_addr = '0;
		cpu_wdata = '0;
		romsz = ROM_BYTES[23:1];
		z80_busack = 1'b0;
		repeat (4) @(posedge MCLK);
		reset <= 1'b0;
		@(negedge MCLK);
		check_value("cpu_dtack", cpu_dtack, 0);
		check_value("rom_req", rom_req, 0);
		check_value("z80_busreq", z80_busreq, 0);
		check_value("z80_reset_n", z80_reset_n, 0);

		fd = $fopen("mbus_golden.txt", "r");
		if (fd == 0) fail_run("Could not open mbus_golden.txt for reading");
		lines_run = 0;
		done = 1'b0;
		while (!done) begin
			code = $fscanf(fd, " %c", op);
			if (code != 1) begin
				done = 1'b1;
			end else if (op == "#") begin
				ch = 0;
				while (ch != 10 && ch != -1) ch = $fgetc(fd);
			end else begin
				code = $fscanf(fd, "%h %h %h %h", f_addr, f_wdata, f_strb, f_exp);
				if (code != 4) fail_run("Malformed line in mbus_golden.txt");
				case (op)
					"W": begin
						bus_cycle(1'b0, f_addr, f_wdata, f_strb, rdata, latency);
						check_value("dtack latency", latency, 3);
					end
					"R": begin
						bus_cycle(1'b1, f_addr, f_wdata, f_strb, rdata, latency);
						check_value("dtack latency", latency, 3);
						check_value("cpu_rdata", rdata, f_exp[15:0]);
					end
					"M": begin
						bus_cycle(1'b1, f_addr, f_wdata, f_strb, rdata, latency);
						check_value("rom_addr", {rom_seen_addr, 1'b0}, f_exp);
						check_value("cpu_rdata", rdata, rom_word(f_exp[23:1]));
					end
					"Z": begin
						@(negedge MCLK);
						check_value("z80_busreq", z80_busreq, f_exp[1]);
						check_value("z80_reset_n", z80_reset_n, f_exp[0]);
					end
					default: fail_run("Unknown operation letter in mbus_golden.txt");
				endcase
				lines_run++;
			end
		end
		$fclose(fd);

		if (lines_run == 0) begin
			fail_run("No transactions found in mbus_golden.txt");
		end else begin
			$display("TEST PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- mbus_golden.txt
# op addr wdata strobes expect, all hex, addresses are 68000 byte addresses
# W write, R read, M ROM read (expect is the ROM byte address), Z pins (expect is busreq, reset_n)
# strobes: bit 1 uds, bit 0 lds
Z 000000 0000 0 0
R A12000 0000 3 4E71
W FF0000 1234 3 0
R FF0000 0000 3 1234
W FF0000 AB99 2 0
R FF0000 0000 3 AB34
W FF0002 5678 3 0
W FF0002 00CD 1 0
R FF0002 0000 3 56CD
R A12000 0000 3 56CD
M 001234 0000 3 001234
R A12000 0000 3 ACBF
M 280000 0000 3 280000
R 500000 0000 3 0000
R A12000 0000 3 A5A5
W A1300B 0009 1 0
W A13001 001F 1 0
M 280000 0000 3 480000
M 28ABCE 0000 3 48ABCE
M 012344 0000 3 012344
R A12000 0000 3 3407
W A11100 0100 2 0
W A11200 0100 2 0
Z 000000 0000 0 3
R A11100 0000 3 3507
R A11200 0000 3 3507
W A11100 0000 1 0
Z 000000 0000 0 3
W A11100 0000 2 0
Z 000000 0000 0 1
R FF0000 0000 3 AB34
R A11100 0000 3 AB34
R A12000 0000 3 AB34
W FFFFFE BEEF 3 0
R FFFFFE 0000 3 BEEF
R E00000 0000 3 AB34

//--- files.f
+incdir+.
mbus_pkg.sv
memmap_pkg.sv
mbus_if.sv
mbus_decode.sv
rom_mapper.sv
work_ram.sv
z80_ctrl_regs.sv
mbus_ctrl.sv
genesis_mbus_top.sv
tb_genesis_mbus.sv

//--- Bender.yml
package:
  name: genesis_mbus

sources:
  - include_dirs:
      - .
    files:
      - mbus_pkg.sv
      - memmap_pkg.sv
      - mbus_if.sv
      - mbus_decode.sv
      - rom_mapper.sv
      - work_ram.sv
      - z80_ctrl_regs.sv
      - mbus_ctrl.sv
      - genesis_mbus_top.sv
  - target: simulation
    files:
      - tb_genesis_mbus.sv
